// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_digital_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src.f ====
src/dcore_pkg.sv
src/adc_unfolding.sv
src/prbs_generator.sv
src/rx_bit_select.sv
src/oneshot_memory.sv
src/prbs_checker.sv
src/digital_core.sv
verification/digital_core_assert.sv
verification/tb_digital_core.sv

// ==== src/adc_unfolding.sv ====
`timescale 1ns/100ps

module adc_unfolding (
    input  logic                               clk_adc,
    input  logic                               rst_n_i,
    input  dcore_pkg::adc_bus_t                adc_bus_i,
    input  logic signed [dcore_pkg::n_adc-1:0] pfd_offset_i,
    output dcore_pkg::code_word_t              codes_o
);
    import dcore_pkg::*;

    code_word_t               codes_d;
    code_word_t               codes_q;
    logic signed [n_code-1:0] offset_ext;

    // sign extension to code width, shared by all slices
    assign offset_ext = pfd_offset_i;

    for (genvar k = 0; k < n_ti; k++) begin : g_slice
        logic signed [n_code-1:0] mag_ext;
        logic signed [n_code-1:0] folded;

        // magnitude is unsigned, pad with zeros
        assign mag_ext = $signed({{(n_code-n_adc){1'b0}}, adc_bus_i[k].mag});

        // restore polarity from the comparator sign
        assign folded = adc_bus_i[k].sign ? mag_ext : -mag_ext;

        assign codes_d[k] = folded - offset_ext;
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            codes_q <= '0;
        end else begin
            codes_q <= codes_d;
        end
    end

    assign codes_o = codes_q;

endmodule

// ==== src/dcore_pkg.sv ====
package dcore_pkg;

    // datapath sizes
    parameter int n_ti   = 4;
    parameter int n_adc  = 8;
    // two extra bits keep magnitude minus offset in range
    parameter int n_code = n_adc + 2;
    parameter int n_prbs = 7;
    parameter int n_cnt  = 32;

    // one ADC slice, sign high means positive
    typedef struct packed {
        logic             sign;
        logic [n_adc-1:0] mag;
    } adc_sample_t;

    // slice 0 sits in the lowest position
    typedef adc_sample_t [n_ti-1:0] adc_bus_t;

    typedef logic signed [n_code-1:0] code_t;
    typedef code_t [n_ti-1:0] code_word_t;

    // bit 0 is the earliest in time
    typedef logic [n_ti-1:0] bit_word_t;

    typedef enum logic {
        SEL_ADC  = 1'b0,
        SEL_BIST = 1'b1
    } bit_sel_e;

    typedef enum logic [1:0] {
        CHK_CLEAR = 2'd0,
        CHK_ALIGN = 2'd1,
        CHK_RUN   = 2'd2
    } chk_mode_e;

    // static settings, held between tests
    typedef struct packed {
        logic signed [n_adc-1:0]  pfd_offset;
        logic signed [n_code-1:0] adc_thresh;
        bit_sel_e                 bit_sel;
        logic                     prbs_gen_cke;
        logic                     prbs_cke;
        chk_mode_e                checker_mode;
    } dcore_cfg_t;

endpackage

// ==== src/digital_core.sv ====
`timescale 1ns/100ps

module digital_core #(
    parameter int mem_depth = 16
) (
    input  logic                         clk_adc,
    input  logic                         rst_n_i,
    input  dcore_pkg::adc_bus_t          adc_bus_i,
    input  dcore_pkg::dcore_cfg_t        cfg_i,
    input  logic                         dump_start_i,
    input  logic                         inj_err_i,
    input  logic [$clog2(mem_depth)-1:0] rd_addr_i,
    output dcore_pkg::code_word_t        rd_data_o,
    output logic                         capture_done_o,
    output logic [dcore_pkg::n_cnt-1:0]  err_count_o,
    output logic [dcore_pkg::n_cnt-1:0]  total_count_o
);
    import dcore_pkg::*;

    code_word_t codes;
    bit_word_t  bist_bits;
    bit_word_t  rx_bits;

    // unfolding front end
    adc_unfolding u_unfold (
        .clk_adc      (clk_adc),
        .rst_n_i      (rst_n_i),
        .adc_bus_i    (adc_bus_i),
        .pfd_offset_i (cfg_i.pfd_offset),
        .codes_o      (codes)
    );

    // BIST source
    prbs_generator u_prbs_gen (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .cke_i     (cfg_i.prbs_gen_cke),
        .inj_err_i (inj_err_i),
        .bits_o    (bist_bits)
    );

    // decisions and source mux toward the checker
    rx_bit_select u_bit_sel (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .codes_i     (codes),
        .thresh_i    (cfg_i.adc_thresh),
        .bist_bits_i (bist_bits),
        .bit_sel_i   (cfg_i.bit_sel),
        .bits_o      (rx_bits)
    );

    oneshot_memory #(
        .mem_depth (mem_depth)
    ) u_capture (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .codes_i   (codes),
        .start_i   (dump_start_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .done_o    (capture_done_o)
    );

    prbs_checker u_prbs_chk (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n_i),
        .cke_i         (cfg_i.prbs_cke),
        .mode_i        (cfg_i.checker_mode),
        .bits_i        (rx_bits),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

// ==== src/oneshot_memory.sv ====
`timescale 1ns/100ps

module oneshot_memory #(
    parameter int mem_depth = 16
) (
    input  logic                         clk_adc,
    input  logic                         rst_n_i,
    input  dcore_pkg::code_word_t        codes_i,
    input  logic                         start_i,
    input  logic [$clog2(mem_depth)-1:0] rd_addr_i,
    output dcore_pkg::code_word_t        rd_data_o,
    output logic                         done_o
);
    import dcore_pkg::*;

    localparam int addr_w = $clog2(mem_depth);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        CAPTURE = 2'd1,
        DONE    = 2'd2
    } mem_state_e;

    mem_state_e        state_q;
    logic [addr_w-1:0] wr_addr_q;
    logic              last_word;
    code_word_t        mem_q [mem_depth];
    code_word_t        rd_data_q;

    assign last_word = (wr_addr_q == addr_w'(mem_depth - 1));

    // burst control, a start while capturing is dropped
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            wr_addr_q <= '0;
        end else begin
            case (state_q)
                IDLE, DONE: begin
                    if (start_i) begin
                        state_q   <= CAPTURE;
                        wr_addr_q <= '0;
                    end
                end
                CAPTURE: begin
                    if (last_word) begin
                        state_q <= DONE;
                    end
                    wr_addr_q <= wr_addr_q + 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // storage write
    always_ff @(posedge clk_adc) begin
        if (state_q == CAPTURE) begin
            mem_q[wr_addr_q] <= codes_i;
        end
    end

    // registered read port
    always_ff @(posedge clk_adc) begin
        rd_data_q <= mem_q[rd_addr_i];
    end

    assign rd_data_o = rd_data_q;
    assign done_o    = (state_q == DONE);

endmodule

// ==== src/prbs_checker.sv ====
`timescale 1ns/100ps

module prbs_checker (
    input  logic                       clk_adc,
    input  logic                       rst_n_i,
    input  logic                       cke_i,
    input  dcore_pkg::chk_mode_e       mode_i,
    input  dcore_pkg::bit_word_t       bits_i,
    output logic [dcore_pkg::n_cnt-1:0] err_count_o,
    output logic [dcore_pkg::n_cnt-1:0] total_count_o
);
    import dcore_pkg::*;

    localparam int num_w = $clog2(n_ti + 1);

    // received history in time order, index 0 is the oldest
    logic [n_prbs-1:0]      hist_q;
    logic [n_prbs+n_ti-1:0] ext;
    bit_word_t              pred;
    bit_word_t              err_flags;
    logic [num_w-1:0]       err_num;
    logic [n_cnt-1:0]       err_q;
    logic [n_cnt-1:0]       total_q;

    assign ext = {bits_i, hist_q};

    // predict from what was received, not from a local generator,
    // so the checker locks on to any phase of the sequence
    for (genvar i = 0; i < n_ti; i++) begin : g_pred
        assign pred[i] = ext[n_prbs+i-6] ^ ext[n_prbs+i-7];
    end

    assign err_flags = pred ^ bits_i;

    // number of mismatches in this word
    always_comb begin
        err_num = '0;
        for (int i = 0; i < n_ti; i++) begin
            err_num = err_num + {{(num_w-1){1'b0}}, err_flags[i]};
        end
    end

    // history follows the stream in align and run modes
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_q <= '0;
        end else if (cke_i && (mode_i == CHK_ALIGN || mode_i == CHK_RUN)) begin
            hist_q <= ext[n_ti +: n_prbs];
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q   <= '0;
            total_q <= '0;
        end else if (mode_i == CHK_CLEAR) begin
            err_q   <= '0;
            total_q <= '0;
        end else if (cke_i && mode_i == CHK_RUN) begin
            err_q   <= err_q + n_cnt'(err_num);
            total_q <= total_q + n_cnt'(n_ti);
        end
    end

    assign err_count_o   = err_q;
    assign total_count_o = total_q;

endmodule

// ==== src/prbs_generator.sv ====
`timescale 1ns/100ps

module prbs_generator (
    input  logic                 clk_adc,
    input  logic                 rst_n_i,
    input  logic                 cke_i,
    input  logic                 inj_err_i,
    output dcore_pkg::bit_word_t bits_o
);
    import dcore_pkg::*;

    // history in time order, index 0 is the oldest bit
    logic [n_prbs-1:0]      state_q;
    logic [n_prbs+n_ti-1:0] seq;
    bit_word_t              word;

    // extend the history by one word of PRBS7 bits
    always_comb begin
        seq = '0;
        seq[n_prbs-1:0] = state_q;
        for (int i = 0; i < n_ti; i++) begin
            // x^7 + x^6 + 1: taps six and seven bits back
            seq[n_prbs+i] = seq[n_prbs+i-6] ^ seq[n_prbs+i-7];
        end
    end

    assign word = seq[n_prbs +: n_ti];

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // all-ones seed
            state_q <= '1;
        end else if (cke_i) begin
            state_q <= seq[n_ti +: n_prbs];
        end
    end

    // error injection flips only the output, the state runs on
    assign bits_o = word ^ {{(n_ti-1){1'b0}}, inj_err_i};

endmodule

// ==== src/rx_bit_select.sv ====
`timescale 1ns/100ps

module rx_bit_select (
    input  logic                                clk_adc,
    input  logic                                rst_n_i,
    input  dcore_pkg::code_word_t               codes_i,
    input  logic signed [dcore_pkg::n_code-1:0] thresh_i,
    input  dcore_pkg::bit_word_t                bist_bits_i,
    input  dcore_pkg::bit_sel_e                 bit_sel_i,
    output dcore_pkg::bit_word_t                bits_o
);
    import dcore_pkg::*;

    bit_word_t sliced;
    bit_word_t bits_d;
    bit_word_t bits_q;

    // one decision per slice, signed compare
    for (genvar k = 0; k < n_ti; k++) begin : g_slice
        assign sliced[k] = ($signed(codes_i[k]) > thresh_i);
    end

    always_comb begin
        case (bit_sel_i)
            SEL_BIST: bits_d = bist_bits_i;
            default:  bits_d = sliced;
        endcase
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_q <= '0;
        end else begin
            bits_q <= bits_d;
        end
    end

    assign bits_o = bits_q;

endmodule

// ==== verification/digital_core_assert.sv ====
`timescale 1ns/100ps

module digital_core_assert (
    input logic                        clk_adc,
    input logic                        rst_n_i,
    input dcore_pkg::dcore_cfg_t       cfg_i,
    input logic                        dump_start_i,
    input logic                        capture_done_o,
    input logic [dcore_pkg::n_cnt-1:0] err_count_o,
    input logic [dcore_pkg::n_cnt-1:0] total_count_o
);
    import dcore_pkg::*;

    int unsigned fail_count = 0;
    logic        counting;
    logic        clearing;

    assign counting = cfg_i.prbs_cke && (cfg_i.checker_mode == CHK_RUN);
    assign clearing = (cfg_i.checker_mode == CHK_CLEAR);

    // first edge after reset release
    a_reset_state: assert property (@(posedge clk_adc)
        $rose(rst_n_i) |-> (err_count_o == '0 && total_count_o == '0 && !capture_done_o))
    else begin
        $error("counters or capture_done_o not at reset values after reset");
        fail_count++;
    end

    a_total_step: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        counting |=> (total_count_o == $past(total_count_o) + n_cnt'(n_ti)))
    else begin
        $error("total_count_o did not grow by one word on a counting cycle");
        fail_count++;
    end

    a_total_hold: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        (!counting && !clearing) |=> $stable(total_count_o))
    else begin
        $error("total_count_o changed while the checker was not counting");
        fail_count++;
    end

    a_err_hold: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        (!counting && !clearing) |=> $stable(err_count_o))
    else begin
        $error("err_count_o changed while the checker was not counting");
        fail_count++;
    end

    a_clear: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        clearing |=> (err_count_o == '0 && total_count_o == '0))
    else begin
        $error("clear mode did not zero the counters on the next cycle");
        fail_count++;
    end

    a_done_hold: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        (capture_done_o && !dump_start_i) |=> capture_done_o)
    else begin
        $error("capture_done_o dropped without a dump start");
        fail_count++;
    end

    a_done_rearm: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        dump_start_i |=> !capture_done_o)
    else begin
        $error("capture_done_o still high after a dump start");
        fail_count++;
    end

endmodule

bind digital_core digital_core_assert u_assert (
    .clk_adc        (clk_adc),
    .rst_n_i        (rst_n_i),
    .cfg_i          (cfg_i),
    .dump_start_i   (dump_start_i),
    .capture_done_o (capture_done_o),
    .err_count_o    (err_count_o),
    .total_count_o  (total_count_o)
);

// ==== verification/tb_digital_core.sv ====
`timescale 1ns/100ps

module tb_digital_core;
    import dcore_pkg::*;

    localparam int mem_depth = 16;
    localparam int addr_w    = $clog2(mem_depth);

    logic              clk_adc;
    logic              rst_n_i;
    adc_bus_t          adc_bus;
    dcore_cfg_t        cfg;
    logic              dump_start;
    logic              inj_err;
    logic [addr_w-1:0] rd_addr;
    code_word_t        rd_data;
    logic              capture_done;
    logic [n_cnt-1:0]  err_count;
    logic [n_cnt-1:0]  total_count;

    logic [31:0]       lfsr;
    // reference PRBS7 history, index 0 is the oldest bit
    logic [n_prbs-1:0] model_hist;
    adc_bus_t          sent [mem_depth];
    int                check_errors;

    digital_core #(
        .mem_depth (mem_depth)
    ) u_dut (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .adc_bus_i      (adc_bus),
        .cfg_i          (cfg),
        .dump_start_i   (dump_start),
        .inj_err_i      (inj_err),
        .rd_addr_i      (rd_addr),
        .rd_data_o      (rd_data),
        .capture_done_o (capture_done),
        .err_count_o    (err_count),
        .total_count_o  (total_count)
    );

    initial begin
        clk_adc = 1'b0;
        forever begin
            #50 clk_adc = ~clk_adc;
        end
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // signed code from sign/magnitude, less the offset
    function automatic code_t expected_code(input adc_sample_t s,
                                            input logic signed [n_adc-1:0] off);
        int value;
        value = int'(s.mag);
        if (!s.sign) begin
            value = -value;
        end
        value = value - int'(off);
        return code_t'(value);
    endfunction

    task automatic drive_random_bus();
        logic [31:0] r;
        for (int k = 0; k < n_ti; k++) begin
            draw_bits(n_adc + 1, r);
            adc_bus[k] = r[n_adc:0];
        end
    endtask

    // each new bit is the XOR of the bits six and seven back
    task automatic drive_prbs_bus();
        logic [31:0] r;
        logic        b;
        for (int k = 0; k < n_ti; k++) begin
            b = model_hist[1] ^ model_hist[0];
            model_hist = {b, model_hist[n_prbs-1:1]};
            draw_bits(6, r);
            // magnitude at least 64, far from the zero threshold
            adc_bus[k].sign = b;
            adc_bus[k].mag  = n_adc'(64 + r[5:0]);
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk_adc);
    endtask

    task automatic adc_cycles(input int n);
        repeat (n) begin
            @(negedge clk_adc);
            drive_prbs_bus();
        end
    endtask

    task automatic check_count(input string name, input logic [n_cnt-1:0] got,
                               input logic [n_cnt-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            check_errors++;
        end
    endtask

    initial begin
        logic [31:0]      r;
        int               waited;
        logic [n_cnt-1:0] err_before;
        code_t            exp_code;

        lfsr         = 32'h9ddf;
        check_errors = 0;
        model_hist   = 7'h5b;
        rst_n_i      = 1'b0;
        adc_bus      = '0;
        cfg          = '0;
        dump_start   = 1'b0;
        inj_err      = 1'b0;
        rd_addr      = '0;
        run_cycles(16);
        rst_n_i = 1'b1;

        // capture memory with random samples
        draw_bits(n_adc, r);
        cfg.pfd_offset = r[n_adc-1:0];
        @(negedge clk_adc);
        drive_random_bus();
        dump_start = 1'b1;
        sent[0]    = adc_bus;
        for (int i = 1; i < mem_depth; i++) begin
            @(negedge clk_adc);
            dump_start = 1'b0;
            drive_random_bus();
            sent[i] = adc_bus;
        end
        waited = 0;
        while (!capture_done && waited < 4 * mem_depth) begin
            @(negedge clk_adc);
            dump_start = 1'b0;
            waited++;
        end
        if (!capture_done) begin
            $display("timeout: capture_done_o never rose after the dump start");
            check_errors++;
        end else begin
            for (int a = 0; a < mem_depth; a++) begin
                rd_addr = addr_w'(a);
                @(negedge clk_adc);
                for (int k = 0; k < n_ti; k++) begin
                    exp_code = expected_code(sent[a][k], cfg.pfd_offset);
                    if (rd_data[k] !== exp_code) begin
                        $display("mismatch rd_data_o[%0d] at address %0d: got %h expected %h",
                                 k, a, rd_data[k], exp_code);
                        check_errors++;
                    end
                end
            end
        end

        // BIST stream, no errors expected
        cfg.bit_sel      = SEL_BIST;
        cfg.prbs_gen_cke = 1'b1;
        cfg.prbs_cke     = 1'b1;
        cfg.checker_mode = CHK_CLEAR;
        run_cycles(2);
        cfg.checker_mode = CHK_ALIGN;
        run_cycles(4);
        cfg.checker_mode = CHK_RUN;
        run_cycles(20);
        // counters hold while aligning
        cfg.checker_mode = CHK_ALIGN;
        run_cycles(3);
        cfg.checker_mode = CHK_RUN;
        run_cycles(10);
        check_count("err_count_o", err_count, '0);
        check_count("total_count_o", total_count, n_cnt'(30 * n_ti));

        // one injected error shows up three times
        cfg.checker_mode = CHK_CLEAR;
        run_cycles(2);
        cfg.checker_mode = CHK_ALIGN;
        run_cycles(4);
        cfg.checker_mode = CHK_RUN;
        run_cycles(5);
        err_before = err_count;
        inj_err    = 1'b1;
        run_cycles(1);
        inj_err = 1'b0;
        run_cycles(10);
        check_count("err_count_o", err_count, err_before + n_cnt'(3));
        cfg.checker_mode = CHK_CLEAR;
        run_cycles(1);
        check_count("err_count_o", err_count, '0);
        check_count("total_count_o", total_count, '0);

        // ADC path carrying a PRBS7 pattern
        cfg.bit_sel      = SEL_ADC;
        cfg.pfd_offset   = 8'sd3;
        cfg.adc_thresh   = '0;
        cfg.checker_mode = CHK_CLEAR;
        drive_prbs_bus();
        adc_cycles(3);
        cfg.checker_mode = CHK_ALIGN;
        adc_cycles(6);
        cfg.checker_mode = CHK_RUN;
        adc_cycles(20);
        check_count("err_count_o", err_count, '0);
        check_count("total_count_o", total_count, n_cnt'(20 * n_ti));

        run_cycles(2);
        $display("errors: checks %0d, assertions %0d", check_errors, u_dut.u_assert.fail_count);
        if (check_errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
